// ==== Makefile ====
# Verilator build and run for the pipelined CPU testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) src/cpu_params.svh
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+src
src/cpu_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/id_ex.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/cpu_top.sv
tb/cpu_mem_model.sv
tb/cpu_tb.sv

// ==== src/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data and instruction words share one width
`define WORD_SIZE 16

// four general registers, addressed by a two-bit field
`define NUM_REGS 4
`define REG_IDX_W 2

// fetch starts here after reset
`define RESET_PC 16'h0000

`endif

// ==== src/cpu_pkg.sv ====
`include "cpu_params.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_RTYPE = 4'd15
    } opcode_e;

    // WWD and HLT live in the R-type group
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } func_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_PASS_B = 3'd4,
        ALU_LHI    = 3'd5
    } alu_op_e;

    typedef struct packed {
        opcode_e               opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [`REG_IDX_W-1:0] rd;
        func_e                 func;
    } r_fmt_t;

    typedef struct packed {
        opcode_e               opcode;
        logic [`REG_IDX_W-1:0] rs;
        logic [`REG_IDX_W-1:0] rt;
        logic [7:0]            imm;
    } i_fmt_t;

    typedef struct packed {
        opcode_e    opcode;
        logic [11:0] target;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_u;

endpackage

// ==== src/cpu_top.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [`WORD_SIZE-1:0] i_data,
    input  logic [`WORD_SIZE-1:0] d_rdata,
    output logic [`WORD_SIZE-1:0] i_addr,
    output logic [`WORD_SIZE-1:0] d_addr,
    output logic [`WORD_SIZE-1:0] d_wdata,
    output logic                  d_read,
    output logic                  d_write,
    output logic [`WORD_SIZE-1:0] out_value,
    output logic                  out_valid,
    output logic                  halted
);

    ////////////////////////////////////////
    // pipeline nets

    logic [`WORD_SIZE-1:0] if_pc, id_pc, ex_pc, redirect_pc;
    instr_u                if_instr;
    logic [`WORD_SIZE-1:0] id_rs_data, id_rt_data, id_imm;
    logic [`WORD_SIZE-1:0] ex_rs_data, ex_rt_data, ex_imm;
    logic [`REG_IDX_W-1:0] id_rd, ex_rd, m_rd, wb_rd;
    alu_op_e               id_alu_op, ex_alu_op;
    logic [11:0]           id_jump_target, ex_jump_target;
    logic                  id_alu_src_b, id_mem_read, id_mem_write, id_reg_write;
    logic                  id_mem_to_reg, id_is_branch, id_branch_ne, id_is_jump;
    logic                  id_is_wwd, id_is_halt;
    logic                  ex_alu_src_b, ex_mem_read, ex_mem_write, ex_reg_write;
    logic                  ex_mem_to_reg, ex_is_branch, ex_branch_ne, ex_is_jump;
    logic                  ex_is_wwd, ex_is_halt;
    logic [`WORD_SIZE-1:0] m_alu_result, m_store_data, wb_data;
    logic                  m_reg_write, m_mem_read, m_mem_write, m_mem_to_reg;
    logic                  m_is_wwd, m_is_halt;
    logic                  stall, redirect, flush, wb_en, wb_halt;

    fetch_stage fetch_i (.*);

    // hazard checks look at the writers in execute and memory
    decode_stage decode_i (
        .ex_we  (ex_reg_write),
        .mem_rd (m_rd),
        .mem_we (m_reg_write),
        .*
    );

    id_ex id_ex_i (.*);

    execute_stage execute_i (.*);

    mem_wb_stage mem_wb_i (.*);

endmodule

// ==== src/decode_stage.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [`WORD_SIZE-1:0] if_pc,
    input  instr_u                if_instr,
    input  logic                  wb_en,
    input  logic [`REG_IDX_W-1:0] wb_rd,
    input  logic [`WORD_SIZE-1:0] wb_data,
    input  logic                  wb_halt,
    input  logic [`REG_IDX_W-1:0] ex_rd,
    input  logic                  ex_we,
    input  logic [`REG_IDX_W-1:0] mem_rd,
    input  logic                  mem_we,
    input  logic                  flush,
    output logic                  stall,
    output logic                  halted,
    output logic [`WORD_SIZE-1:0] id_pc,
    output logic [`WORD_SIZE-1:0] id_rs_data,
    output logic [`WORD_SIZE-1:0] id_rt_data,
    output logic [`WORD_SIZE-1:0] id_imm,
    output logic [`REG_IDX_W-1:0] id_rd,
    output alu_op_e               id_alu_op,
    output logic                  id_alu_src_b,
    output logic                  id_mem_read,
    output logic                  id_mem_write,
    output logic                  id_reg_write,
    output logic                  id_mem_to_reg,
    output logic                  id_is_branch,
    output logic                  id_branch_ne,
    output logic                  id_is_jump,
    output logic [11:0]           id_jump_target,
    output logic                  id_is_wwd,
    output logic                  id_is_halt
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];
    logic [`REG_IDX_W-1:0] rs;
    logic [`REG_IDX_W-1:0] rt;
    logic                  use_rs;
    logic                  use_rt;
    logic                  hazard;
    logic                  halt_pending;

    assign rs             = if_instr.r.rs;
    assign rt             = if_instr.r.rt;
    assign id_pc          = if_pc;
    assign id_jump_target = if_instr.j.target;

    ////////////////////////////////////////
    // control decode

    always_comb begin
        id_imm        = {{(`WORD_SIZE-8){if_instr.i.imm[7]}}, if_instr.i.imm};
        id_rd         = if_instr.i.rt;
        id_alu_op     = ALU_PASS_B;
        id_alu_src_b  = 1'b1;
        id_mem_read   = 1'b0;
        id_mem_write  = 1'b0;
        id_reg_write  = 1'b0;
        id_mem_to_reg = 1'b0;
        id_is_branch  = 1'b0;
        id_branch_ne  = 1'b0;
        id_is_jump    = 1'b0;
        id_is_wwd     = 1'b0;
        id_is_halt    = 1'b0;
        use_rs        = 1'b0;
        use_rt        = 1'b0;
        // once a halt has issued, younger instructions are dropped here
        if (!halt_pending) begin
            case (if_instr.r.opcode)
                OP_RTYPE: begin
                    id_rd        = if_instr.r.rd;
                    id_alu_src_b = 1'b0;
                    case (if_instr.r.func)
                        FN_ADD, FN_SUB, FN_AND, FN_ORR: begin
                            // function codes 0 to 3 line up with the ALU encoding
                            id_alu_op    = alu_op_e'(if_instr.r.func[2:0]);
                            id_reg_write = 1'b1;
                            use_rs       = 1'b1;
                            use_rt       = 1'b1;
                        end
                        FN_WWD: begin
                            id_is_wwd = 1'b1;
                            use_rs    = 1'b1;
                        end
                        FN_HLT: id_is_halt = 1'b1;
                        default: ;
                    endcase
                end
                OP_ADI: begin
                    id_alu_op    = ALU_ADD;
                    id_reg_write = 1'b1;
                    use_rs       = 1'b1;
                end
                OP_ORI: begin
                    id_imm       = {{(`WORD_SIZE-8){1'b0}}, if_instr.i.imm};
                    id_alu_op    = ALU_OR;
                    id_reg_write = 1'b1;
                    use_rs       = 1'b1;
                end
                OP_LHI: begin
                    id_alu_op    = ALU_LHI;
                    id_reg_write = 1'b1;
                end
                OP_LWD: begin
                    id_alu_op     = ALU_ADD;
                    id_mem_read   = 1'b1;
                    id_mem_to_reg = 1'b1;
                    id_reg_write  = 1'b1;
                    use_rs        = 1'b1;
                end
                OP_SWD: begin
                    id_alu_op    = ALU_ADD;
                    id_mem_write = 1'b1;
                    use_rs       = 1'b1;
                    use_rt       = 1'b1;
                end
                OP_BNE, OP_BEQ: begin
                    id_is_branch = 1'b1;
                    id_branch_ne = (if_instr.r.opcode == OP_BNE);
                    use_rs       = 1'b1;
                    use_rt       = 1'b1;
                end
                OP_JMP: id_is_jump = 1'b1;
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////
    // register file and interlock

    // a writeback in this cycle is visible to the read
    assign id_rs_data = (wb_en && wb_rd == rs) ? wb_data : regs[rs];
    assign id_rt_data = (wb_en && wb_rd == rt) ? wb_data : regs[rt];

    assign hazard = (use_rs && ((ex_we && ex_rd == rs) || (mem_we && mem_rd == rs)))
                 || (use_rt && ((ex_we && ex_rd == rt) || (mem_we && mem_rd == rt)));
    // the instruction here is squashed by a flush, so it must not hold fetch
    assign stall = hazard && !flush;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            halt_pending <= 1'b0;
            halted       <= 1'b0;
        end else begin
            if (id_is_halt && !flush)
                halt_pending <= 1'b1;
            if (wb_halt)
                halted <= 1'b1;
        end
    end

    // the producer reaches writeback within three stall cycles
    assert property (@(posedge clk) disable iff (reset_n)
        stall && $past(stall) && $past(stall, 2) |=> !stall)
        else $error("decode interlock did not release");

endmodule

// ==== src/execute_stage.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [`WORD_SIZE-1:0] ex_pc,
    input  logic [`WORD_SIZE-1:0] ex_rs_data,
    input  logic [`WORD_SIZE-1:0] ex_rt_data,
    input  logic [`WORD_SIZE-1:0] ex_imm,
    input  logic [`REG_IDX_W-1:0] ex_rd,
    input  alu_op_e               ex_alu_op,
    input  logic                  ex_alu_src_b,
    input  logic                  ex_mem_read,
    input  logic                  ex_mem_write,
    input  logic                  ex_reg_write,
    input  logic                  ex_mem_to_reg,
    input  logic                  ex_is_branch,
    input  logic                  ex_branch_ne,
    input  logic                  ex_is_jump,
    input  logic [11:0]           ex_jump_target,
    input  logic                  ex_is_wwd,
    input  logic                  ex_is_halt,
    output logic                  redirect,
    output logic [`WORD_SIZE-1:0] redirect_pc,
    output logic                  flush,
    output logic [`WORD_SIZE-1:0] m_alu_result,
    output logic [`WORD_SIZE-1:0] m_store_data,
    output logic [`REG_IDX_W-1:0] m_rd,
    output logic                  m_reg_write,
    output logic                  m_mem_read,
    output logic                  m_mem_write,
    output logic                  m_mem_to_reg,
    output logic                  m_is_wwd,
    output logic                  m_is_halt
);

    logic [`WORD_SIZE-1:0] op_b;
    logic [`WORD_SIZE-1:0] alu_out;
    logic                  taken;

    assign op_b = ex_alu_src_b ? ex_imm : ex_rt_data;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:    alu_out = ex_rs_data + op_b;
            ALU_SUB:    alu_out = ex_rs_data - op_b;
            ALU_AND:    alu_out = ex_rs_data & op_b;
            ALU_OR:     alu_out = ex_rs_data | op_b;
            ALU_PASS_B: alu_out = op_b;
            ALU_LHI:    alu_out = {op_b[7:0], 8'h00};
            default:    alu_out = '0;
        endcase
    end

    ////////////////////////////////////////
    // branch resolution

    // BNE inverts the equality test of BEQ
    assign taken    = ex_is_branch && ((ex_rs_data == ex_rt_data) ^ ex_branch_ne);
    assign redirect = taken || ex_is_jump;
    assign flush    = redirect;

    assign redirect_pc = ex_is_jump ? {ex_pc[`WORD_SIZE-1:12], ex_jump_target}
                                    : ex_pc + `WORD_SIZE'(1) + ex_imm;

    always_ff @(posedge clk) begin
        m_alu_result <= alu_out;
        m_store_data <= ex_is_wwd ? ex_rs_data : ex_rt_data;
        m_rd         <= ex_rd;
        m_mem_to_reg <= ex_mem_to_reg;
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            m_reg_write <= 1'b0;
            m_mem_read  <= 1'b0;
            m_mem_write <= 1'b0;
            m_is_wwd    <= 1'b0;
            m_is_halt   <= 1'b0;
        end else begin
            m_reg_write <= ex_reg_write;
            m_mem_read  <= ex_mem_read;
            m_mem_write <= ex_mem_write;
            m_is_wwd    <= ex_is_wwd;
            m_is_halt   <= ex_is_halt;
        end
    end

endmodule

// ==== src/fetch_stage.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  stall,
    input  logic                  redirect,
    input  logic [`WORD_SIZE-1:0] redirect_pc,
    input  logic                  flush,
    input  logic                  halted,
    input  logic [`WORD_SIZE-1:0] i_data,
    output logic [`WORD_SIZE-1:0] i_addr,
    output logic [`WORD_SIZE-1:0] if_pc,
    output instr_u                if_instr
);

    // an R-type word with an unused function code decodes to nothing
    localparam logic [`WORD_SIZE-1:0] BUBBLE = {OP_RTYPE, 12'hfff};

    logic [`WORD_SIZE-1:0] pc;

    assign i_addr = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= `RESET_PC;
        end else if (!halted) begin
            if (redirect)
                pc <= redirect_pc;
            else if (!stall)
                pc <= pc + `WORD_SIZE'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_n || flush || halted) begin
            if_instr <= BUBBLE;
        end else if (!stall) begin
            if_instr <= i_data;
            if_pc    <= pc;
        end
    end

    // decode drops its stall whenever execute redirects
    assert property (@(posedge clk) disable iff (reset_n)
        redirect |-> !stall)
        else $error("fetch held by a stall during a redirect");

endmodule

// ==== src/id_ex.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module id_ex
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  stall,
    input  logic                  flush,
    input  logic [`WORD_SIZE-1:0] id_pc,
    input  logic [`WORD_SIZE-1:0] id_rs_data,
    input  logic [`WORD_SIZE-1:0] id_rt_data,
    input  logic [`WORD_SIZE-1:0] id_imm,
    input  logic [`REG_IDX_W-1:0] id_rd,
    input  alu_op_e               id_alu_op,
    input  logic                  id_alu_src_b,
    input  logic                  id_mem_read,
    input  logic                  id_mem_write,
    input  logic                  id_reg_write,
    input  logic                  id_mem_to_reg,
    input  logic                  id_is_branch,
    input  logic                  id_branch_ne,
    input  logic                  id_is_jump,
    input  logic [11:0]           id_jump_target,
    input  logic                  id_is_wwd,
    input  logic                  id_is_halt,
    output logic [`WORD_SIZE-1:0] ex_pc,
    output logic [`WORD_SIZE-1:0] ex_rs_data,
    output logic [`WORD_SIZE-1:0] ex_rt_data,
    output logic [`WORD_SIZE-1:0] ex_imm,
    output logic [`REG_IDX_W-1:0] ex_rd,
    output alu_op_e               ex_alu_op,
    output logic                  ex_alu_src_b,
    output logic                  ex_mem_read,
    output logic                  ex_mem_write,
    output logic                  ex_reg_write,
    output logic                  ex_mem_to_reg,
    output logic                  ex_is_branch,
    output logic                  ex_branch_ne,
    output logic                  ex_is_jump,
    output logic [11:0]           ex_jump_target,
    output logic                  ex_is_wwd,
    output logic                  ex_is_halt
);

    always_ff @(posedge clk) begin
        ex_pc          <= id_pc;
        ex_rs_data     <= id_rs_data;
        ex_rt_data     <= id_rt_data;
        ex_imm         <= id_imm;
        ex_rd          <= id_rd;
        ex_alu_op      <= id_alu_op;
        ex_alu_src_b   <= id_alu_src_b;
        ex_mem_to_reg  <= id_mem_to_reg;
        ex_branch_ne   <= id_branch_ne;
        ex_jump_target <= id_jump_target;
    end

    // a bubble carries no side effects
    always_ff @(posedge clk) begin
        if (reset_n || stall || flush) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_is_wwd    <= 1'b0;
            ex_is_halt   <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_is_jump   <= 1'b0;
        end else begin
            ex_reg_write <= id_reg_write;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_is_wwd    <= id_is_wwd;
            ex_is_halt   <= id_is_halt;
            ex_is_branch <= id_is_branch;
            ex_is_jump   <= id_is_jump;
        end
    end

    // an instruction is at most one of load, store, output, halt, branch or jump
    assert property (@(posedge clk) disable iff (reset_n)
        $onehot0({ex_mem_read, ex_mem_write, ex_is_wwd, ex_is_halt, ex_is_branch,
                  ex_is_jump}))
        else $error("execute holds more than one operation kind");

endmodule

// ==== src/mem_wb_stage.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module mem_wb_stage (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [`WORD_SIZE-1:0] m_alu_result,
    input  logic [`WORD_SIZE-1:0] m_store_data,
    input  logic [`REG_IDX_W-1:0] m_rd,
    input  logic                  m_reg_write,
    input  logic                  m_mem_read,
    input  logic                  m_mem_write,
    input  logic                  m_mem_to_reg,
    input  logic                  m_is_wwd,
    input  logic                  m_is_halt,
    input  logic [`WORD_SIZE-1:0] d_rdata,
    output logic [`WORD_SIZE-1:0] d_addr,
    output logic [`WORD_SIZE-1:0] d_wdata,
    output logic                  d_read,
    output logic                  d_write,
    output logic                  wb_en,
    output logic [`REG_IDX_W-1:0] wb_rd,
    output logic [`WORD_SIZE-1:0] wb_data,
    output logic [`WORD_SIZE-1:0] out_value,
    output logic                  out_valid,
    output logic                  wb_halt
);

    assign d_addr  = m_alu_result;
    assign d_wdata = m_store_data;
    assign d_read  = m_mem_read;
    assign d_write = m_mem_write;

    always_ff @(posedge clk) begin
        wb_rd   <= m_rd;
        wb_data <= m_mem_to_reg ? d_rdata : m_alu_result;
        // out_value holds the last WWD word between outputs
        if (m_is_wwd)
            out_value <= m_store_data;
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_en     <= 1'b0;
            out_valid <= 1'b0;
            wb_halt   <= 1'b0;
        end else begin
            wb_en     <= m_reg_write;
            out_valid <= m_is_wwd;
            wb_halt   <= m_is_halt;
        end
    end

    assert property (@(posedge clk) disable iff (reset_n) !(d_read && d_write))
        else $error("data port read and write in the same cycle");

endmodule

// ==== tb/cpu_mem_model.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_mem_model
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic [`WORD_SIZE-1:0] i_addr,
    output logic [`WORD_SIZE-1:0] i_data,
    input  logic [`WORD_SIZE-1:0] d_addr,
    input  logic [`WORD_SIZE-1:0] d_wdata,
    input  logic                  d_read,
    input  logic                  d_write,
    output logic [`WORD_SIZE-1:0] d_rdata
);

    localparam int DEPTH = 256;

    logic [`WORD_SIZE-1:0] imem [DEPTH];
    logic [`WORD_SIZE-1:0] dmem [DEPTH];

    initial begin
        instr_u     halt_word;
        logic [7:0] idx;
        halt_word.r.opcode = OP_RTYPE;
        halt_word.r.rs     = 2'd0;
        halt_word.r.rt     = 2'd0;
        halt_word.r.rd     = 2'd0;
        halt_word.r.func   = FN_HLT;
        for (int a = 0; a < DEPTH; a++) begin
            idx = 8'(a);
            // a core that runs past the program stops on its own
            imem[idx] = halt_word;
            // every data word differs, so a load from a wrong address shows up
            dmem[idx] = {idx, idx} ^ 16'hc35a;
        end
    end

    // the program is written here word by word before reset is released
    task automatic load_word(logic [7:0] addr, logic [`WORD_SIZE-1:0] word);
        imem[addr] = word;
    endtask

    assign i_data  = imem[i_addr[7:0]];
    assign d_rdata = d_read ? dmem[d_addr[7:0]] : '0;

    always @(posedge clk) begin
        if (d_write)
            dmem[d_addr[7:0]] <= d_wdata;
    end

endmodule

// ==== tb/cpu_tb.sv ====
`timescale 1ns/10ps
`include "cpu_params.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam logic [1:0] R0 = 2'd0;
    localparam logic [1:0] R1 = 2'd1;
    localparam logic [1:0] R2 = 2'd2;
    localparam logic [1:0] R3 = 2'd3;

    localparam logic [2:0] SEC_RTYPE = 3'd0;
    localparam logic [2:0] SEC_IMM   = 3'd1;
    localparam logic [2:0] SEC_MEM   = 3'd2;
    localparam logic [2:0] SEC_CHAIN = 3'd3;
    localparam logic [2:0] SEC_FLOW  = 3'd4;
    localparam logic [2:0] SEC_HALT  = 3'd5;
    localparam int         NUM_SECS  = 6;

    logic                  clk;
    logic                  reset_n;
    logic [`WORD_SIZE-1:0] i_addr, i_data, d_addr, d_wdata, d_rdata, out_value;
    logic                  d_read, d_write, out_valid, halted;

    integer                seed;
    int                    prog_len;
    int                    pc_cnt;
    int                    errors;
    int                    passed;
    int                    failed;
    logic [7:0]            st_addr;
    logic [`WORD_SIZE-1:0] st_val;
    logic [`WORD_SIZE-1:0] exp_val [$];
    logic [2:0]            exp_sec [$];
    int                    sec_errs [8];
    logic                  sec_done [8];
    string                 sec_name [8];

    cpu_top dut_i (.*);

    cpu_mem_model mem_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////////////////////////
    // program building

    function automatic logic [7:0] next_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [`WORD_SIZE-1:0] sign_extend(logic [7:0] b);
        return {{8{b[7]}}, b};
    endfunction

    function automatic instr_u r_word(func_e fn, logic [1:0] rs, logic [1:0] rt,
                                      logic [1:0] rd);
        instr_u w;
        w.r.opcode = OP_RTYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.func   = fn;
        return w;
    endfunction

    function automatic instr_u i_word(opcode_e op, logic [1:0] rs, logic [1:0] rt,
                                      logic [7:0] imm);
        instr_u w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic instr_u j_word(logic [11:0] target);
        instr_u w;
        w.j.opcode = OP_JMP;
        w.j.target = target;
        return w;
    endfunction

    task automatic emit(instr_u w);
        mem_i.load_word(8'(pc_cnt), w);
        pc_cnt++;
    endtask

    task automatic emit_wwd(logic [1:0] rs, logic [`WORD_SIZE-1:0] value, logic [2:0] sec,
                            bit expected);
        emit(r_word(FN_WWD, rs, R0, R0));
        if (expected) begin
            exp_val.push_back(value);
            exp_sec.push_back(sec);
        end
    endtask

    task automatic build_program();
        logic [7:0]            ah, al, bh, bl, imm, k0, k1, k2;
        logic [`WORD_SIZE-1:0] va, vb, c1, c2, c3;
        ah = next_byte();
        al = next_byte();
        bh = next_byte();
        bl = next_byte();
        va = {ah, al};
        vb = {bh, bl};
        // operands are assembled a byte at a time
        emit(i_word(OP_LHI, R0, R1, ah));
        emit(i_word(OP_ORI, R1, R1, al));
        emit(i_word(OP_LHI, R0, R2, bh));
        emit(i_word(OP_ORI, R2, R2, bl));
        emit(r_word(FN_ADD, R1, R2, R3));
        emit_wwd(R3, va + vb, SEC_RTYPE, 1'b1);
        emit(r_word(FN_SUB, R1, R2, R3));
        emit_wwd(R3, va - vb, SEC_RTYPE, 1'b1);
        emit(r_word(FN_AND, R1, R2, R3));
        emit_wwd(R3, va & vb, SEC_RTYPE, 1'b1);
        emit(r_word(FN_ORR, R1, R2, R3));
        emit_wwd(R3, va | vb, SEC_RTYPE, 1'b1);

        // top bit forced so sign and zero extension give different words
        imm = next_byte() | 8'h80;
        emit(i_word(OP_ADI, R1, R0, imm));
        emit_wwd(R0, va + sign_extend(imm), SEC_IMM, 1'b1);
        imm = next_byte() | 8'h80;
        emit(i_word(OP_ORI, R2, R0, imm));
        emit_wwd(R0, vb | {8'h00, imm}, SEC_IMM, 1'b1);
        imm = next_byte();
        emit(i_word(OP_LHI, R0, R0, imm));
        emit_wwd(R0, {imm, 8'h00}, SEC_IMM, 1'b1);

        imm     = next_byte();
        st_addr = {3'b010, imm[4:0]};
        st_val  = va;
        emit(i_word(OP_LHI, R0, R0, 8'h00));
        emit(i_word(OP_SWD, R0, R1, st_addr));
        emit(i_word(OP_LWD, R0, R2, st_addr));
        emit_wwd(R2, va, SEC_MEM, 1'b1);

        k0 = next_byte();
        k1 = next_byte();
        k2 = next_byte();
        c1 = sign_extend(k0) + sign_extend(k1);
        c2 = c1 + sign_extend(k2);
        c3 = c2 + c1;
        emit(i_word(OP_ADI, R0, R1, k0));
        emit(i_word(OP_ADI, R1, R1, k1));
        emit(i_word(OP_ADI, R1, R2, k2));
        emit(r_word(FN_ADD, R2, R1, R3));
        emit(r_word(FN_SUB, R3, R2, R1));
        emit_wwd(R1, c3 - c2, SEC_CHAIN, 1'b1);
        emit_wwd(R3, c3, SEC_CHAIN, 1'b1);
        emit_wwd(R2, c2, SEC_CHAIN, 1'b1);

        // r2 and r3 start equal and the shadow slots print r0, which is zero
        emit(i_word(OP_ADI, R0, R2, 8'd5));
        emit(i_word(OP_ADI, R0, R3, 8'd5));
        emit(i_word(OP_BEQ, R2, R3, 8'd2));
        emit_wwd(R0, '0, SEC_FLOW, 1'b0);
        emit_wwd(R0, '0, SEC_FLOW, 1'b0);
        emit(i_word(OP_ADI, R2, R2, 8'd1));
        emit(i_word(OP_BNE, R2, R3, 8'd1));
        emit_wwd(R0, '0, SEC_FLOW, 1'b0);
        emit_wwd(R2, 16'd6, SEC_FLOW, 1'b1);
        emit(i_word(OP_BEQ, R2, R3, 8'd1));
        emit_wwd(R3, 16'd5, SEC_FLOW, 1'b1);
        emit(i_word(OP_BNE, R3, R3, 8'd1));
        emit_wwd(R2, 16'd6, SEC_FLOW, 1'b1);
        emit(j_word(12'(pc_cnt + 3)));
        emit(i_word(OP_ADI, R3, R3, 8'd1));
        emit_wwd(R0, '0, SEC_FLOW, 1'b0);
        emit_wwd(R3, 16'd5, SEC_FLOW, 1'b1);

        emit(r_word(FN_HLT, R0, R0, R0));
        emit_wwd(R2, '0, SEC_HALT, 1'b0);
        emit_wwd(R3, '0, SEC_HALT, 1'b0);
    endtask

    ////////////////////////////////////////
    // checking

    task automatic report_section(logic [2:0] sec);
        sec_done[sec] = 1'b1;
        if (sec_errs[sec] == 0) begin
            passed++;
            $display("test %0d %s: ok", sec, sec_name[sec]);
        end else begin
            failed++;
            $display("test %0d %s: FAILED with %0d errors", sec, sec_name[sec], sec_errs[sec]);
        end
    endtask

    task automatic check_output();
        logic [`WORD_SIZE-1:0] want;
        logic [2:0]            sec;
        assert (exp_val.size() > 0) else begin
            $display("unexpected WWD output %h at %0t with nothing left to expect",
                     out_value, $time);
            errors++;
            sec_errs[SEC_HALT]++;
        end
        if (exp_val.size() > 0) begin
            want = exp_val.pop_front();
            sec  = exp_sec.pop_front();
            assert (out_value == want) else begin
                $display("ERROR t=%0t out_value expected %h got %h", $time, want, out_value);
                errors++;
                sec_errs[sec]++;
            end
            if (exp_sec.size() == 0 || exp_sec[0] != sec) begin
                if (sec == SEC_MEM) begin
                    assert (mem_i.dmem[st_addr] == st_val) else begin
                        $display("ERROR t=%0t dmem[%h] expected %h got %h", $time, st_addr,
                                 st_val, mem_i.dmem[st_addr]);
                        errors++;
                        sec_errs[sec]++;
                    end
                end
                report_section(sec);
            end
        end
    endtask

    // outputs are registered on the rising edge, so the falling edge sees them settled
    always @(negedge clk) begin
        if (!reset_n && out_valid && !halted)
            check_output();
    end

    initial begin
        wait (prog_len > 0);
        repeat (prog_len * 8 + 50) @(posedge clk);
        $display("TIMEOUT: the core never halted within %0d cycles", prog_len * 8 + 50);
        $display("RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // main sequence

    initial begin
        logic [2:0]            sec;
        logic [`WORD_SIZE-1:0] lost;
        reset_n   = 1'b1;
        seed      = 71;
        prog_len  = 0;
        pc_cnt    = 0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        for (int s = 0; s < 8; s++) begin
            sec_errs[3'(s)] = 0;
            sec_done[3'(s)] = 1'b0;
        end
        sec_name[SEC_RTYPE] = "r-type arithmetic";
        sec_name[SEC_IMM]   = "immediates";
        sec_name[SEC_MEM]   = "store and load";
        sec_name[SEC_CHAIN] = "dependent chain";
        sec_name[SEC_FLOW]  = "branches and jump";
        sec_name[SEC_HALT]  = "halt";

        @(negedge clk);
        build_program();
        prog_len = pc_cnt;
        repeat (3) @(negedge clk);
        reset_n = 1'b0;

        while (!halted)
            @(negedge clk);
        assert (exp_val.size() == 0) else begin
            $display("core halted at %0t with %0d expected outputs never seen", $time,
                     exp_val.size());
            while (exp_val.size() > 0) begin
                lost = exp_val.pop_front();
                sec  = exp_sec.pop_front();
                $display("expected output %h of test %0d never appeared", lost, sec);
                errors++;
                sec_errs[sec]++;
            end
        end
        repeat (12) begin
            assert (halted) else begin
                $display("halted fell again at %0t", $time);
                errors++;
                sec_errs[SEC_HALT]++;
            end
            assert (!out_valid) else begin
                $display("out_valid rose at %0t after the core halted", $time);
                errors++;
                sec_errs[SEC_HALT]++;
            end
            @(negedge clk);
        end

        for (int s = 0; s < NUM_SECS - 1; s++) begin
            if (!sec_done[3'(s)])
                report_section(3'(s));
        end
        report_section(SEC_HALT);
        $display("tests %0d, passed %0d, failed %0d, errors %0d", NUM_SECS, passed, failed,
                 errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule
